//--- convImg.f
+incdir+include
hdl/convImgPkg.sv
hdl/gpioCommandDecoder.sv
hdl/pixelFifo.sv
hdl/convolutionEngine.sv
hdl/convImgTop.sv
test/convImgTb.sv

//--- hdl/convImgPkg.sv
`default_nettype none

package convImgPkg;

  ////////////////////////////////////////
  // Widths and depths
  ////////////////////////////////////////

  // GPIO side
  localparam int GPIO_W    = 32;
  localparam int OP_W      = 3;
  localparam int PAYLOAD_W = 24;

  // Pixel and kernel data
  localparam int PIX_W  = 8;
  localparam int COEF_W = 8;
  // Signed coefficient times zero-extended pixel
  localparam int PROD_W = COEF_W + PIX_W + 1;
  // Three products summed
  localparam int RES_W  = 18;

  // Line buffer and result store
  localparam int BUF_DEPTH = 256;
  localparam int ADDR_W    = 8;
  // Length field as carried in the command word
  localparam int LEN_W     = 11;

  ////////////////////////////////////////
  // Command encoding
  ////////////////////////////////////////

  // Codes 5 to 7 are ignored by the decoder
  typedef enum logic [OP_W-1:0] {
    OP_KERNEL = 3'd0,
    OP_LENGTH = 3'd1,
    OP_PIXEL  = 3'd2,
    OP_READ   = 3'd3,
    OP_START  = 3'd4
  } opcode_e;

  // k0 in the low byte
  typedef struct packed {
    logic signed [COEF_W-1:0] k2;
    logic signed [COEF_W-1:0] k1;
    logic signed [COEF_W-1:0] k0;
  } kernel_t;

  // Length, pixel or read address view
  typedef struct packed {
    logic [4:0]       spare;
    logic [LEN_W-1:0] length;
    logic [PIX_W-1:0] value;
  } payloadFields_t;

  typedef union packed {
    kernel_t        kernel;
    payloadFields_t fields;
  } payload_u;

  ////////////////////////////////////////
  // Block to block bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic [PIX_W-1:0] pixel;
    logic             last;
  } pixelBeat_t;

  typedef struct packed {
    logic            start;
    kernel_t         kernel;
    logic [ADDR_W:0] length;
  } convCtrl_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } readReq_t;

  typedef struct packed {
    logic                    valid;
    logic signed [RES_W-1:0] data;
  } readResp_t;

endpackage

`default_nettype wire

//--- hdl/convImgTop.sv
`timescale 1ns/1ps
`default_nettype none

module convImgTop (
  input  wire logic                            i_CLK,
  input  wire logic                            i_rst,
  input  wire logic                            i_gpioValid,
  input  wire logic [convImgPkg::OP_W-1:0]     i_gpioOpcode,
  input  wire logic [convImgPkg::PAYLOAD_W-1:0] i_gpioPayload,
  output logic [convImgPkg::GPIO_W-1:0]        o_gpioData,
  output logic                                 o_busy,
  output logic                                 o_done
);

  // Decoder to FIFO
  convImgPkg::pixelBeat_t decBeat;
  logic                   decValid;
  logic                   fifoInReady;
  // FIFO to engine
  convImgPkg::pixelBeat_t fifoBeat;
  logic                   fifoValid;
  logic                   engReady;
  // Control and readback between decoder and engine
  convImgPkg::convCtrl_t  convCtrl;
  convImgPkg::readReq_t   readReq;
  convImgPkg::readResp_t  readResp;
  logic                   convDone;

  // Producer
  gpioCommandDecoder u_decoder (
    .i_CLK         (i_CLK),
    .i_rst         (i_rst),
    .i_gpioValid   (i_gpioValid),
    .i_gpioOpcode  (convImgPkg::opcode_e'(i_gpioOpcode)),
    .i_gpioPayload (i_gpioPayload),
    .i_pixReady    (fifoInReady),
    .i_readResp    (readResp),
    .i_convDone    (convDone),
    .o_pixBeat     (decBeat),
    .o_pixValid    (decValid),
    .o_convCtrl    (convCtrl),
    .o_readReq     (readReq),
    .o_gpioData    (o_gpioData),
    .o_busy        (o_busy),
    .o_done        (o_done)
  );

  // Line buffer
  pixelFifo u_fifo (
    .i_CLK      (i_CLK),
    .i_rst      (i_rst),
    .i_inBeat   (decBeat),
    .i_inValid  (decValid),
    .i_outReady (engReady),
    .o_inReady  (fifoInReady),
    .o_outBeat  (fifoBeat),
    .o_outValid (fifoValid)
  );

  // Consumer with result store
  convolutionEngine u_engine (
    .i_CLK      (i_CLK),
    .i_rst      (i_rst),
    .i_convCtrl (convCtrl),
    .i_pixBeat  (fifoBeat),
    .i_pixValid (fifoValid),
    .i_readReq  (readReq),
    .o_pixReady (engReady),
    .o_readResp (readResp),
    .o_convDone (convDone)
  );

endmodule

`default_nettype wire

//--- hdl/convolutionEngine.sv
`timescale 1ns/1ps
`default_nettype none

module convolutionEngine (
  input  wire logic                   i_CLK,
  input  wire logic                   i_rst,
  input  wire convImgPkg::convCtrl_t  i_convCtrl,
  input  wire convImgPkg::pixelBeat_t i_pixBeat,
  input  wire logic                   i_pixValid,
  input  wire convImgPkg::readReq_t   i_readReq,
  output logic                        o_pixReady,
  output convImgPkg::readResp_t       o_readResp,
  output logic                        o_convDone
);

  // Run control
  logic running;
  logic pop;
  logic doneQ;
  // Kernel latched at start
  convImgPkg::kernel_t kern;
  // Previous two pixels of the line
  logic [convImgPkg::PIX_W-1:0] hist1;
  logic [convImgPkg::PIX_W-1:0] hist2;
  // Multiply stage
  logic s1Valid;
  logic s1Last;
  logic signed [convImgPkg::PROD_W-1:0] prod0;
  logic signed [convImgPkg::PROD_W-1:0] prod1;
  logic signed [convImgPkg::PROD_W-1:0] prod2;
  // Sum and write stage
  logic signed [convImgPkg::RES_W-1:0]  sum;
  logic [convImgPkg::ADDR_W-1:0]        wrAddr;
  logic signed [convImgPkg::RES_W-1:0]  resMem [convImgPkg::BUF_DEPTH];
  // Readback port
  logic                                 respValid;
  logic signed [convImgPkg::RES_W-1:0]  respData;

  // Accept pixels only during a run
  assign o_pixReady = running;
  assign pop        = running & i_pixValid;

  ////////////////////////////////////////
  // Run control and write address
  ////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      running <= 1'b0;
      s1Valid <= 1'b0;
      doneQ   <= 1'b0;
      wrAddr  <= '0;
    end else begin
      doneQ <= 1'b0;
      if (i_convCtrl.start) begin
        // Empty line finishes at once
        running <= (i_convCtrl.length != '0);
        doneQ   <= (i_convCtrl.length == '0);
        s1Valid <= 1'b0;
        wrAddr  <= '0;
      end else begin
        s1Valid <= pop;
        // Stop popping after the last pixel
        if (pop && i_pixBeat.last) begin
          running <= 1'b0;
        end
        if (s1Valid) begin
          wrAddr <= wrAddr + 1'b1;
          // Done one cycle after the last write
          if (s1Last) begin
            doneQ <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Multiply stage
  ////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_convCtrl.start) begin
      kern  <= i_convCtrl.kernel;
      // Pixels before the line start count as zero
      hist1 <= '0;
      hist2 <= '0;
    end else if (pop) begin
      // Pixels are unsigned, zero extended into the signed product
      prod0  <= kern.k0 * $signed({1'b0, i_pixBeat.pixel});
      prod1  <= kern.k1 * $signed({1'b0, hist1});
      prod2  <= kern.k2 * $signed({1'b0, hist2});
      s1Last <= i_pixBeat.last;
      hist1  <= i_pixBeat.pixel;
      hist2  <= hist1;
    end
  end

  // Three products fit RES_W without overflow
  assign sum = prod0 + prod1 + prod2;

  // Result store
  always_ff @(posedge i_CLK) begin
    if (s1Valid) begin
      resMem[wrAddr] <= sum;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Response one cycle after the request
  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      respValid <= 1'b0;
    end else begin
      respValid <= i_readReq.valid;
    end
  end

  always_ff @(posedge i_CLK) begin
    if (i_readReq.valid) begin
      respData <= resMem[i_readReq.addr];
    end
  end

  assign o_readResp = '{valid: respValid, data: respData};
  assign o_convDone = doneQ;

endmodule

`default_nettype wire

//--- hdl/gpioCommandDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module gpioCommandDecoder (
  input  wire logic                   i_CLK,
  input  wire logic                   i_rst,
  input  wire logic                   i_gpioValid,
  input  wire convImgPkg::opcode_e    i_gpioOpcode,
  input  wire convImgPkg::payload_u   i_gpioPayload,
  input  wire logic                   i_pixReady,
  input  wire convImgPkg::readResp_t  i_readResp,
  input  wire logic                   i_convDone,
  output convImgPkg::pixelBeat_t      o_pixBeat,
  output logic                        o_pixValid,
  output convImgPkg::convCtrl_t       o_convCtrl,
  output convImgPkg::readReq_t        o_readReq,
  output logic [convImgPkg::GPIO_W-1:0] o_gpioData,
  output logic                        o_busy,
  output logic                        o_done
);

  // Strobe sampling and edge pulse
  logic validQ1;
  logic validQ2;
  logic cmdStrobe;
  // Command word captured with the edge
  convImgPkg::opcode_e  cmdOp;
  convImgPkg::payload_u cmdPayload;
  // Configuration held for the next run
  convImgPkg::kernel_t  kernReg;
  logic [convImgPkg::ADDR_W:0] lenReg;
  logic [convImgPkg::ADDR_W:0] clipLen;
  // Pixels accepted since the last start
  logic [convImgPkg::ADDR_W:0] pixCount;
  logic [convImgPkg::ADDR_W:0] nextCount;
  logic startQ;
  logic reqValid;
  logic [convImgPkg::ADDR_W-1:0] reqAddr;
  logic pixAccept;
  logic readAccept;

  ////////////////////////////////////////
  // Strobe edge detect
  ////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      validQ1   <= 1'b0;
      validQ2   <= 1'b0;
      cmdStrobe <= 1'b0;
    end else begin
      validQ1   <= i_gpioValid;
      validQ2   <= validQ1;
      // One pulse per rising edge
      cmdStrobe <= validQ1 & ~validQ2;
    end
  end

  // Opcode and payload are stable around the strobe
  always_ff @(posedge i_CLK) begin
    cmdOp      <= i_gpioOpcode;
    cmdPayload <= i_gpioPayload;
  end

  // Lengths beyond the line buffer saturate
  always_comb begin
    if (cmdPayload.fields.length > convImgPkg::LEN_W'(convImgPkg::BUF_DEPTH)) begin
      clipLen = (convImgPkg::ADDR_W+1)'(convImgPkg::BUF_DEPTH);
    end else begin
      clipLen = cmdPayload.fields.length[convImgPkg::ADDR_W:0];
    end
  end

  assign nextCount = pixCount + 1'b1;

  // Only one pending pixel, none past the stored length
  assign pixAccept = cmdStrobe && !o_busy && (cmdOp == convImgPkg::OP_PIXEL) &&
                     !o_pixValid && (pixCount < lenReg);
  // Readback also allowed during a run
  assign readAccept = cmdStrobe && (cmdOp == convImgPkg::OP_READ);

  ////////////////////////////////////////
  // Command decode and run state
  ////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      kernReg    <= '0;
      lenReg     <= '0;
      pixCount   <= '0;
      o_pixValid <= 1'b0;
      startQ     <= 1'b0;
      reqValid   <= 1'b0;
      o_busy     <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      startQ   <= 1'b0;
      reqValid <= readAccept;
      // Pending beat leaves on handshake
      if (o_pixValid && i_pixReady) begin
        o_pixValid <= 1'b0;
      end
      if (pixAccept) begin
        o_pixValid <= 1'b1;
        pixCount   <= nextCount;
      end
      // Loads locked out while running
      if (cmdStrobe && !o_busy) begin
        case (cmdOp)
          convImgPkg::OP_KERNEL: kernReg <= cmdPayload.kernel;
          convImgPkg::OP_LENGTH: lenReg <= clipLen;
          convImgPkg::OP_START: begin
            startQ   <= 1'b1;
            o_busy   <= 1'b1;
            o_done   <= 1'b0;
            pixCount <= '0;
          end
          default: ;
        endcase
      end
      // Run finished, move to the out state
      if (o_busy && i_convDone) begin
        o_busy <= 1'b0;
        o_done <= 1'b1;
      end
    end
  end

  // Pixel beat and read address payloads
  always_ff @(posedge i_CLK) begin
    if (pixAccept) begin
      o_pixBeat.pixel <= cmdPayload.fields.value;
      o_pixBeat.last  <= (nextCount == lenReg);
    end
    if (readAccept) begin
      reqAddr <= cmdPayload.fields.value;
    end
  end

  // Result word, sign extended, held until the next read
  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      o_gpioData <= '0;
    end else if (i_readResp.valid) begin
      o_gpioData <= {{(convImgPkg::GPIO_W-convImgPkg::RES_W){i_readResp.data[convImgPkg::RES_W-1]}},
                     i_readResp.data};
    end
  end

  assign o_convCtrl = '{start: startQ, kernel: kernReg, length: lenReg};
  assign o_readReq  = '{valid: reqValid, addr: reqAddr};

endmodule

`default_nettype wire

//--- hdl/pixelFifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixelFifo (
  input  wire logic                   i_CLK,
  input  wire logic                   i_rst,
  input  wire convImgPkg::pixelBeat_t i_inBeat,
  input  wire logic                   i_inValid,
  input  wire logic                   i_outReady,
  output logic                        o_inReady,
  output convImgPkg::pixelBeat_t      o_outBeat,
  output logic                        o_outValid
);

  // Beat storage
  convImgPkg::pixelBeat_t mem [convImgPkg::BUF_DEPTH];
  // Pointers wrap naturally at the depth
  logic [convImgPkg::ADDR_W-1:0] wrPtr;
  logic [convImgPkg::ADDR_W-1:0] rdPtr;
  // One extra bit to tell full from empty
  logic [convImgPkg::ADDR_W:0]   fillCount;
  logic push;
  logic pop;

  // Full and empty flags
  assign o_inReady  = (fillCount != (convImgPkg::ADDR_W+1)'(convImgPkg::BUF_DEPTH));
  assign o_outValid = (fillCount != '0);

  assign push = i_inValid & o_inReady;
  assign pop  = o_outValid & i_outReady;

  // Head of queue
  assign o_outBeat = mem[rdPtr];

  always_ff @(posedge i_CLK) begin
    if (push) begin
      mem[wrPtr] <= i_inBeat;
    end
  end

  ////////////////////////////////////////
  // Pointer and fill tracking
  ////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   fillCount <= fillCount + 1'b1;
        2'b01:   fillCount <= fillCount - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- include/convImgTbTasks.svh
////////////////////////////////////////
// GPIO command sequences
////////////////////////////////////////

// Strobe high for 2 cycles and low for 2 with the word held throughout
task automatic sendCommand(input logic [2:0] op, input logic [23:0] data);
  @(posedge clk);
  gpioOpcode  <= op;
  gpioPayload <= data;
  gpioValid   <= 1'b1;
  repeat (2) @(posedge clk);
  gpioValid <= 1'b0;
  repeat (2) @(posedge clk);
endtask

// k0 in the low byte
task automatic loadKernel(input int c0, input int c1, input int c2);
  sendCommand(convImgPkg::OP_KERNEL, {c2[7:0], c1[7:0], c0[7:0]});
endtask

// Length sits above the 8-bit value field
task automatic loadLength(input int len);
  sendCommand(convImgPkg::OP_LENGTH, {5'd0, len[10:0], 8'd0});
endtask

task automatic pushLine(input int count);
  for (int n = 0; n < count; n++) begin
    sendCommand(convImgPkg::OP_PIXEL, {16'd0, linePix[n][7:0]});
  end
endtask

task automatic startRun;
  sendCommand(convImgPkg::OP_START, 24'd0);
endtask

// Busy must hold until done shows and drop with it
task automatic waitForDone;
  logic finished;
  finished = 1'b0;
  while (!finished) begin
    @(negedge clk);
    if (done === 1'b1) begin
      finished = 1'b1;
      checkValue("o_busy", 32'd0, {31'd0, busy});
    end else begin
      checkValue("o_busy", 32'd1, {31'd0, busy});
    end
  end
endtask

////////////////////////////////////////
// Reference filter and checks
////////////////////////////////////////

// Three taps with zeros before the line start
function automatic int filterTap(input int n);
  int acc;
  acc = kern0 * linePix[n];
  if (n >= 1) begin
    acc = acc + kern1 * linePix[n-1];
  end
  if (n >= 2) begin
    acc = acc + kern2 * linePix[n-2];
  end
  return acc;
endfunction

task automatic buildModel(input int len);
  for (int n = 0; n < len; n++) begin
    expRes[n] = filterTap(n);
  end
endtask

task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
  checkCount++;
  if (actual !== expected) begin
    errorCount++;
    $display("Fail at %0t: %s expected %0d, got %0d", $time, name,
             $signed(expected), $signed(actual));
  end
endtask

// Result lands on the GPIO data 4 cycles after the strobe is sampled
task automatic readAndCheck(input int addr);
  sendCommand(convImgPkg::OP_READ, {16'd0, addr[7:0]});
  @(posedge clk);
  @(negedge clk);
  checkValue($sformatf("o_gpioData[%0d]", addr), expRes[addr], gpioData);
endtask

//--- test/convImgTb.sv
`timescale 1ns/1ps
`default_nettype none

module convImgTb;

  // Watchdog budget
  localparam int NUM_COMMANDS   = 620;
  localparam int NUM_RUNS       = 6;
  localparam int MAX_LEN        = convImgPkg::BUF_DEPTH;
  localparam int TIMEOUT_CYCLES = NUM_COMMANDS * 10 + NUM_RUNS * MAX_LEN * 4;

  // DUT ports
  logic        clk;
  logic        rst;
  logic        gpioValid;
  logic [2:0]  gpioOpcode;
  logic [23:0] gpioPayload;
  logic [31:0] gpioData;
  logic        busy;
  logic        done;

  // Stimulus and model state
  int kern0;
  int kern1;
  int kern2;
  int lineLen;
  int prevLen;
  int linePix [0:511];
  int expRes [0:255];
  // Result bookkeeping
  int checkCount;
  int errorCount;
  int errorsAtStart;
  int testsPassed;
  int testsFailed;

  convImgTop u_dut (
    .i_CLK         (clk),
    .i_rst         (rst),
    .i_gpioValid   (gpioValid),
    .i_gpioOpcode  (gpioOpcode),
    .i_gpioPayload (gpioPayload),
    .o_gpioData    (gpioData),
    .o_busy        (busy),
    .o_done        (done)
  );

  `include "convImgTbTasks.svh"

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // Signed coefficients in -128..127
  task automatic randomKernel;
    kern0 = int'($urandom_range(0, 255)) - 128;
    kern1 = int'($urandom_range(0, 255)) - 128;
    kern2 = int'($urandom_range(0, 255)) - 128;
  endtask

  task automatic randomLine(input int count);
    for (int n = 0; n < count; n++) begin
      linePix[n] = $urandom_range(0, 255);
    end
  endtask

  task automatic reportTest(input string name);
    if (errorCount == errorsAtStart) begin
      testsPassed++;
      $display("Test %s: passed", name);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errorCount - errorsAtStart);
    end
    errorsAtStart = errorCount;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(58173));
    checkCount    = 0;
    errorCount    = 0;
    errorsAtStart = 0;
    testsPassed   = 0;
    testsFailed   = 0;
    rst         = 1'b1;
    gpioValid   = 1'b0;
    gpioOpcode  = 3'd0;
    gpioPayload = 24'd0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Idle outputs after reset
    @(negedge clk);
    checkValue("o_busy", 32'd0, {31'd0, busy});
    checkValue("o_done", 32'd0, {31'd0, done});
    checkValue("o_gpioData", 32'd0, gpioData);
    reportTest("reset state");

    // One random line through the filter
    randomKernel();
    lineLen = $urandom_range(1, 40);
    randomLine(lineLen);
    loadKernel(kern0, kern1, kern2);
    loadLength(lineLen);
    pushLine(lineLen);
    startRun();
    waitForDone();
    buildModel(lineLen);
    for (int n = 0; n < lineLen; n++) begin
      readAndCheck(n);
    end
    reportTest("filtering");

    // Loads sent mid-run must be dropped
    randomKernel();
    lineLen = $urandom_range(20, 40);
    randomLine(lineLen);
    loadKernel(kern0, kern1, kern2);
    loadLength(lineLen);
    pushLine(lineLen);
    startRun();
    @(negedge clk);
    checkValue("o_busy", 32'd1, {31'd0, busy});
    loadKernel(kern2, kern0, kern1);
    @(negedge clk);
    checkValue("o_busy", 32'd1, {31'd0, busy});
    loadLength($urandom_range(1, 19));
    @(negedge clk);
    checkValue("o_busy", 32'd1, {31'd0, busy});
    sendCommand(convImgPkg::OP_PIXEL, 24'h0000A5);
    waitForDone();
    buildModel(lineLen);
    for (int n = 0; n < lineLen; n++) begin
      readAndCheck(n);
    end
    // Later run reuses the kernel and length stored before the busy loads
    randomLine(lineLen);
    pushLine(lineLen);
    startRun();
    waitForDone();
    buildModel(lineLen);
    for (int n = 0; n < lineLen; n++) begin
      readAndCheck(n);
    end
    reportTest("run control");

    // New kernel and length, done cleared by start
    randomKernel();
    lineLen = $urandom_range(1, 40);
    randomLine(lineLen);
    loadKernel(kern0, kern1, kern2);
    loadLength(lineLen);
    pushLine(lineLen);
    @(negedge clk);
    checkValue("o_done", 32'd1, {31'd0, done});
    startRun();
    @(negedge clk);
    checkValue("o_done", 32'd0, {31'd0, done});
    waitForDone();
    buildModel(lineLen);
    for (int n = 0; n < lineLen; n++) begin
      readAndCheck(n);
    end
    reportTest("back-to-back runs");

    // Empty line leaves the previous results in place
    prevLen = (lineLen < 8) ? lineLen : 8;
    loadLength(0);
    startRun();
    waitForDone();
    for (int n = 0; n < prevLen; n++) begin
      readAndCheck(n);
    end
    // Oversized length saturates at the buffer depth
    randomKernel();
    randomLine(260);
    loadKernel(kern0, kern1, kern2);
    loadLength(300);
    pushLine(260);
    startRun();
    waitForDone();
    buildModel(MAX_LEN);
    readAndCheck(MAX_LEN - 1);
    readAndCheck(0);
    reportTest("clipping and empty line");

    $display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
             testsPassed, testsFailed, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
